// File: backend.f
+incdir+include
hdl/backend_op_pkg.sv
hdl/backend_rob_pkg.sv
hdl/issue_stage.sv
hdl/alu_unit.sv
hdl/mul_unit.sv
hdl/reorder_buffer.sv
hdl/backend_top.sv
verification/tb_clock_gen.sv
verification/backend_monitor.sv
verification/backend_checker.sv
verification/backend_tb.sv

// File: verification/backend_tb.sv
`timescale 1ns/1ps
`default_nettype none

module backend_tb;

    import backend_op_pkg::*;

    localparam int NUM_INSTR   = 400;
    // Reset, then at most two cycles per instruction, then room to drain
    localparam int CYCLE_LIMIT = 16 + 2 * NUM_INSTR + 50;

    logic      clk;
    logic      rst_n;
    logic      issue_valid;
    opcode_t   issue_op;
    word_t     issue_a;
    word_t     issue_b;
    reg_addr_t issue_dest;
    logic      wb_valid;
    reg_addr_t wb_dest;
    word_t     wb_data;

    int          error_count;
    int          issue_count;
    int          wb_count;
    int          issued      = 0;
    int          cycle_count = 0;
    logic [31:0] rng_state   = 32'd14563;

    tb_clock_gen tb_clock_gen_inst (
        .clk_o   ( clk   ),
        .rst_n_o ( rst_n )
    );

    backend_top backend_top_inst (
        .clk_i         ( clk         ),
        .rst_n_i       ( rst_n       ),
        .issue_valid_i ( issue_valid ),
        .issue_op_i    ( issue_op    ),
        .issue_a_i     ( issue_a     ),
        .issue_b_i     ( issue_b     ),
        .issue_dest_i  ( issue_dest  ),
        .wb_valid_o    ( wb_valid    ),
        .wb_dest_o     ( wb_dest     ),
        .wb_data_o     ( wb_data     )
    );

    backend_monitor backend_monitor_inst (
        .clk_i         ( clk         ),
        .rst_n_i       ( rst_n       ),
        .issue_valid_i ( issue_valid ),
        .issue_op_i    ( issue_op    ),
        .issue_a_i     ( issue_a     ),
        .issue_b_i     ( issue_b     ),
        .issue_dest_i  ( issue_dest  ),
        .wb_valid_i    ( wb_valid    ),
        .wb_dest_i     ( wb_dest     ),
        .wb_data_i     ( wb_data     ),
        .error_count_o ( error_count ),
        .issue_count_o ( issue_count ),
        .wb_count_o    ( wb_count    )
    );

    // Bookkeeping assertions sit inside the reorder buffer
    bind reorder_buffer backend_checker backend_checker_inst (
        .clk_i         ( clk_i         ),
        .rst_n_i       ( rst_n_i       ),
        .alloc_valid_i ( alloc_valid_i ),
        .alloc_tag_i   ( alloc_tag_i   ),
        .alu_done_i    ( alu_done_i    ),
        .alu_tag_i     ( alu_tag_i     ),
        .mul_done_i    ( mul_done_i    ),
        .mul_tag_i     ( mul_tag_i     ),
        .head_i        ( head_q        ),
        .state_i       ( state_q       ),
        .wb_valid_i    ( wb_valid_o    )
    );

    // LCG step, the upper half has the better randomness
    function automatic logic [15:0] next_rand();
        rng_state = rng_state * 32'd1103515245 + 32'd12345;
        return rng_state[31:16];
    endfunction

    task automatic finish_run(input bit timed_out);
        int assert_errors;
        assert_errors = backend_top_inst.reorder_buffer_inst.backend_checker_inst.assert_errors;
        $display("error counts: compare %0d, assertion %0d, issued %0d, written back %0d",
                 error_count, assert_errors, issue_count, wb_count);
        if (!timed_out && (error_count == 0) && (assert_errors == 0)
                && (issue_count == wb_count) && (issue_count == NUM_INSTR)) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    endtask

    // ============================================================
    // Stimulus
    // ============================================================

    initial begin : drive_stimulus
        logic [15:0] r;
        issue_valid = 1'b0;
        issue_op    = OP_ADD;
        issue_a     = '0;
        issue_b     = '0;
        issue_dest  = '0;
        wait (rst_n === 1'b1);
        // Three issues in four cycles on average, so multiplies often come back to back
        while (issued < NUM_INSTR) begin
            @(posedge clk);
            r = next_rand();
            if (r[15:14] != 2'b00) begin
                issue_valid <= 1'b1;
                issue_op    <= opcode_t'(r[2:0]);
                issue_dest  <= r[8:4];
                issue_a     <= {next_rand(), next_rand()};
                issue_b     <= {next_rand(), next_rand()};
                issued++;
            end else begin
                issue_valid <= 1'b0;
            end
        end
        @(posedge clk);
        issue_valid <= 1'b0;
        // Drain, then a few idle cycles to catch any stray writeback
        while (wb_count < NUM_INSTR) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);
        finish_run(1'b0);
    end

    always @(posedge clk) begin : watchdog
        cycle_count <= cycle_count + 1;
        if (cycle_count == CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, only %0d of %0d instructions were written back",
                     cycle_count, wb_count, NUM_INSTR);
            finish_run(1'b1);
        end
    end

endmodule : backend_tb

`default_nettype wire

// File: verification/backend_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "backend_consts.svh"

module backend_checker (
    input  logic                         clk_i,
    input  logic                         rst_n_i,
    input  logic                         alloc_valid_i,
    input  backend_rob_pkg::tag_t        alloc_tag_i,
    input  logic                         alu_done_i,
    input  backend_rob_pkg::tag_t        alu_tag_i,
    input  logic                         mul_done_i,
    input  backend_rob_pkg::tag_t        mul_tag_i,
    input  backend_rob_pkg::tag_t        head_i,
    input  backend_rob_pkg::entry_state_t state_i [`BACKEND_ROB_DEPTH],
    input  logic                         wb_valid_i
);

    import backend_rob_pkg::*;

    int   assert_errors = 0;
    logic head_done;

    // The head is done when its result is already stored as DONE,
    // or when it is still PENDING and its own completion arrives in this cycle
    // A FREE head never counts, whatever the completion ports carry
    assign head_done = (state_i[head_i] == ENTRY_DONE)
                    || ((state_i[head_i] == ENTRY_PENDING)
                        && ((alu_done_i && (alu_tag_i == head_i))
                            || (mul_done_i && (mul_tag_i == head_i))));

    // ============================================================
    // Reorder bookkeeping
    // ============================================================

    completion_on_live_entry: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !((alu_done_i && (state_i[alu_tag_i] == ENTRY_FREE))
          || (mul_done_i && (state_i[mul_tag_i] == ENTRY_FREE))))
        else begin
            $error("a completion targeted a free reorder entry");
            assert_errors++;
        end

    distinct_completion_tags: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(alu_done_i && mul_done_i && (alu_tag_i == mul_tag_i)))
        else begin
            $error("both completion ports carried the same tag");
            assert_errors++;
        end

    // No writeback strobe unless the head was done the cycle before
    wb_after_done_head: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !head_done |=> !wb_valid_i)
        else begin
            $error("a writeback followed a head that was not done");
            assert_errors++;
        end

    alloc_on_free_entry: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        alloc_valid_i |-> (state_i[alloc_tag_i] == ENTRY_FREE))
        else begin
            $error("an allocation landed on an entry still in use");
            assert_errors++;
        end

endmodule : backend_checker

`default_nettype wire

// File: verification/backend_monitor.sv
`timescale 1ns/1ps
`default_nettype none

module backend_monitor (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  logic                      issue_valid_i,
    input  backend_op_pkg::opcode_t   issue_op_i,
    input  backend_op_pkg::word_t     issue_a_i,
    input  backend_op_pkg::word_t     issue_b_i,
    input  backend_op_pkg::reg_addr_t issue_dest_i,
    input  logic                      wb_valid_i,
    input  backend_op_pkg::reg_addr_t wb_dest_i,
    input  backend_op_pkg::word_t     wb_data_i,
    output int                        error_count_o,
    output int                        issue_count_o,
    output int                        wb_count_o
);

    import backend_op_pkg::*;

    // Expected writebacks, oldest first, so issue order is the compare order
    reg_addr_t exp_dest_q [$];
    word_t     exp_data_q [$];
    string     exp_name_q [$];

    // Reference model of every opcode, written from the opcode rules
    function automatic word_t model_result(input opcode_t op, input word_t a, input word_t b);
        logic [63:0] product;
        product = {32'd0, a} * {32'd0, b};
        case (op)
            OP_ADD:   return a + b;
            OP_SUB:   return a - b;
            OP_AND:   return a & b;
            OP_OR:    return a | b;
            OP_XOR:   return a ^ b;
            OP_SLL:   return a << b[4:0];
            OP_MUL:   return product[31:0];
            OP_MULHU: return product[63:32];
            default:  return '0;
        endcase
    endfunction

    initial begin
        error_count_o = 0;
        issue_count_o = 0;
        wb_count_o    = 0;
    end

    // Sampled on the falling edge, half a cycle away from every driven change
    always @(negedge clk_i) begin
        if (!rst_n_i) begin
            if (wb_valid_i === 1'b1) begin
                error_count_o++;
                $display("a writeback strobe was seen while reset was asserted");
            end
        end else begin
            if (issue_valid_i) begin
                exp_dest_q.push_back(issue_dest_i);
                exp_data_q.push_back(model_result(issue_op_i, issue_a_i, issue_b_i));
                exp_name_q.push_back($sformatf("%s #%0d", issue_op_i.name(), issue_count_o));
                issue_count_o++;
            end
            if (wb_valid_i) begin
                wb_count_o++;
                if (exp_name_q.size() == 0) begin
                    error_count_o++;
                    $display("a writeback came with no instruction outstanding");
                end else begin
                    // Destination and data are checked separately
                    if (wb_dest_i !== exp_dest_q[0]) begin
                        error_count_o++;
                        $display("error %s dest expected %0d actual %0d",
                                 exp_name_q[0], exp_dest_q[0], wb_dest_i);
                    end
                    if (wb_data_i !== exp_data_q[0]) begin
                        error_count_o++;
                        $display("error %s data expected %h actual %h",
                                 exp_name_q[0], exp_data_q[0], wb_data_i);
                    end
                    void'(exp_dest_q.pop_front());
                    void'(exp_data_q.pop_front());
                    void'(exp_name_q.pop_front());
                end
            end
        end
    end

endmodule : backend_monitor

`default_nettype wire

// File: verification/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk_o,
    output logic rst_n_o
);

    // 100 ns period, so each half lasts 50 ns
    localparam int HALF_PERIOD_NS = 50;
    localparam int RESET_CYCLES   = 16;

    initial begin
        clk_o = 1'b0;
        forever #(HALF_PERIOD_NS) clk_o = ~clk_o;
    end

    // Reset is released on a rising edge, like any other driven input
    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        rst_n_o <= 1'b1;
    end

endmodule : tb_clock_gen

`default_nettype wire

// File: hdl/backend_top.sv
`timescale 1ns/1ps
`default_nettype none

module backend_top (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  logic                      issue_valid_i,
    input  backend_op_pkg::opcode_t   issue_op_i,
    input  backend_op_pkg::word_t     issue_a_i,
    input  backend_op_pkg::word_t     issue_b_i,
    input  backend_op_pkg::reg_addr_t issue_dest_i,
    output logic                      wb_valid_o,
    output backend_op_pkg::reg_addr_t wb_dest_o,
    output backend_op_pkg::word_t     wb_data_o
);

    import backend_op_pkg::*;
    import backend_rob_pkg::*;

    // ============================================================
    // Issue to execution
    // ============================================================

    logic      alu_start;
    opcode_t   alu_op;
    logic      mul_start;
    logic      mul_high;
    word_t     op_a;
    word_t     op_b;
    reg_addr_t dest;
    tag_t      tag;
    logic      alloc_valid;

    issue_stage issue_stage_inst (
        .clk_i         ( clk_i         ),
        .rst_n_i       ( rst_n_i       ),
        .issue_valid_i ( issue_valid_i ),
        .issue_op_i    ( issue_op_i    ),
        .issue_a_i     ( issue_a_i     ),
        .issue_b_i     ( issue_b_i     ),
        .issue_dest_i  ( issue_dest_i  ),
        .alu_start_o   ( alu_start     ),
        .alu_op_o      ( alu_op        ),
        .mul_start_o   ( mul_start     ),
        .mul_high_o    ( mul_high      ),
        .op_a_o        ( op_a          ),
        .op_b_o        ( op_b          ),
        .dest_o        ( dest          ),
        .tag_o         ( tag           ),
        .alloc_valid_o ( alloc_valid   )
    );

    // ============================================================
    // Execution units
    // ============================================================

    logic      alu_done;
    tag_t      alu_done_tag;
    reg_addr_t alu_done_dest;
    word_t     alu_result;
    logic      mul_done;
    tag_t      mul_done_tag;
    reg_addr_t mul_done_dest;
    word_t     mul_result;

    alu_unit alu_unit_inst (
        .clk_i       ( clk_i         ),
        .rst_n_i     ( rst_n_i       ),
        .start_i     ( alu_start     ),
        .op_i        ( alu_op        ),
        .a_i         ( op_a          ),
        .b_i         ( op_b          ),
        .dest_i      ( dest          ),
        .tag_i       ( tag           ),
        .done_o      ( alu_done      ),
        .done_tag_o  ( alu_done_tag  ),
        .done_dest_o ( alu_done_dest ),
        .result_o    ( alu_result    )
    );

    // Several multiplies may be in flight while the ALU completes younger ones
    mul_unit mul_unit_inst (
        .clk_i       ( clk_i         ),
        .rst_n_i     ( rst_n_i       ),
        .start_i     ( mul_start     ),
        .high_i      ( mul_high      ),
        .a_i         ( op_a          ),
        .b_i         ( op_b          ),
        .dest_i      ( dest          ),
        .tag_i       ( tag           ),
        .done_o      ( mul_done      ),
        .done_tag_o  ( mul_done_tag  ),
        .done_dest_o ( mul_done_dest ),
        .result_o    ( mul_result    )
    );

    // ============================================================
    // Reordering and writeback
    // ============================================================

    reorder_buffer reorder_buffer_inst (
        .clk_i         ( clk_i         ),
        .rst_n_i       ( rst_n_i       ),
        .alloc_valid_i ( alloc_valid   ),
        .alloc_tag_i   ( tag           ),
        .alu_done_i    ( alu_done      ),
        .alu_tag_i     ( alu_done_tag  ),
        .alu_dest_i    ( alu_done_dest ),
        .alu_result_i  ( alu_result    ),
        .mul_done_i    ( mul_done      ),
        .mul_tag_i     ( mul_done_tag  ),
        .mul_dest_i    ( mul_done_dest ),
        .mul_result_i  ( mul_result    ),
        .wb_valid_o    ( wb_valid_o    ),
        .wb_dest_o     ( wb_dest_o     ),
        .wb_data_o     ( wb_data_o     )
    );

endmodule : backend_top

`default_nettype wire

// File: hdl/reorder_buffer.sv
`timescale 1ns/1ps
`default_nettype none

`include "backend_consts.svh"

module reorder_buffer (
    input  logic                      clk_i,
    input  logic                      rst_n_i,

    // Allocation from the issue stage
    input  logic                      alloc_valid_i,
    input  backend_rob_pkg::tag_t     alloc_tag_i,

    // Completion port of the ALU
    input  logic                      alu_done_i,
    input  backend_rob_pkg::tag_t     alu_tag_i,
    input  backend_op_pkg::reg_addr_t alu_dest_i,
    input  backend_op_pkg::word_t     alu_result_i,

    // Completion port of the multiplier
    input  logic                      mul_done_i,
    input  backend_rob_pkg::tag_t     mul_tag_i,
    input  backend_op_pkg::reg_addr_t mul_dest_i,
    input  backend_op_pkg::word_t     mul_result_i,

    // In-order writeback
    output logic                      wb_valid_o,
    output backend_op_pkg::reg_addr_t wb_dest_o,
    output backend_op_pkg::word_t     wb_data_o
);

    import backend_op_pkg::*;
    import backend_rob_pkg::*;

    // ============================================================
    // Entry storage
    // ============================================================

    entry_state_t state_q  [`BACKEND_ROB_DEPTH];
    reg_addr_t    dest_q   [`BACKEND_ROB_DEPTH];
    word_t        result_q [`BACKEND_ROB_DEPTH];

    // Oldest entry still waiting for writeback
    tag_t head_q;

    logic      alu_hit;
    logic      mul_hit;
    logic      head_ready;
    reg_addr_t head_dest;
    word_t     head_data;

    // A completion for the head entry can retire straight away
    assign alu_hit = alu_done_i && (alu_tag_i == head_q);
    assign mul_hit = mul_done_i && (mul_tag_i == head_q);

    // Head is ready when already stored as DONE or completing right now
    always_comb begin
        head_ready = 1'b1;
        head_dest  = dest_q[head_q];
        head_data  = result_q[head_q];
        if (state_q[head_q] != ENTRY_DONE) begin
            if (alu_hit) begin
                head_dest = alu_dest_i;
                head_data = alu_result_i;
            end else if (mul_hit) begin
                head_dest = mul_dest_i;
                head_data = mul_result_i;
            end else begin
                head_ready = 1'b0;
            end
        end
    end

    // Entry states, head pointer and the writeback strobe
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < `BACKEND_ROB_DEPTH; i++) begin
                state_q[i] <= ENTRY_FREE;
            end
            head_q     <= '0;
            wb_valid_o <= 1'b0;
        end else begin
            if (alloc_valid_i) begin
                state_q[alloc_tag_i] <= ENTRY_PENDING;
            end
            if (alu_done_i) begin
                state_q[alu_tag_i] <= ENTRY_DONE;
            end
            if (mul_done_i) begin
                state_q[mul_tag_i] <= ENTRY_DONE;
            end
            wb_valid_o <= head_ready;
            // Retiring the head overrides a completion landing on it
            if (head_ready) begin
                state_q[head_q] <= ENTRY_FREE;
                head_q          <= head_q + 1'b1;
            end
        end
    end

    // Results land in their tag slot, two ports can write in one cycle
    always_ff @(posedge clk_i) begin
        if (alu_done_i) begin
            dest_q[alu_tag_i]   <= alu_dest_i;
            result_q[alu_tag_i] <= alu_result_i;
        end
        if (mul_done_i) begin
            dest_q[mul_tag_i]   <= mul_dest_i;
            result_q[mul_tag_i] <= mul_result_i;
        end
        if (head_ready) begin
            wb_dest_o <= head_dest;
            wb_data_o <= head_data;
        end
    end

endmodule : reorder_buffer

`default_nettype wire

// File: hdl/mul_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "backend_consts.svh"

module mul_unit (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  logic                      start_i,
    input  logic                      high_i,
    input  backend_op_pkg::word_t     a_i,
    input  backend_op_pkg::word_t     b_i,
    input  backend_op_pkg::reg_addr_t dest_i,
    input  backend_rob_pkg::tag_t     tag_i,
    output logic                      done_o,
    output backend_rob_pkg::tag_t     done_tag_o,
    output backend_op_pkg::reg_addr_t done_dest_o,
    output backend_op_pkg::word_t     result_o
);

    import backend_op_pkg::*;
    import backend_rob_pkg::*;

    localparam int LAT = `BACKEND_MUL_LATENCY;

    // Full unsigned product of the incoming operands
    logic [2*`BACKEND_DATA_WIDTH-1:0] product;

    // One slot per pipeline stage, slot LAT-1 is the output
    logic [LAT-1:0]                   vld_q;
    logic [2*`BACKEND_DATA_WIDTH-1:0] prod_q [LAT];
    logic                             high_q [LAT];
    tag_t                             tag_q  [LAT];
    reg_addr_t                        dest_q [LAT];

    assign product = a_i * b_i;

    // Valid bits shift every cycle so a new multiply can enter each cycle
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            vld_q <= '0;
        end else begin
            vld_q[0] <= start_i;
            for (int i = 1; i < LAT; i++) begin
                vld_q[i] <= vld_q[i-1];
            end
        end
    end

    // Payload follows its valid bit through the stages
    always_ff @(posedge clk_i) begin
        prod_q[0] <= product;
        high_q[0] <= high_i;
        tag_q[0]  <= tag_i;
        dest_q[0] <= dest_i;
        for (int i = 1; i < LAT; i++) begin
            prod_q[i] <= prod_q[i-1];
            high_q[i] <= high_q[i-1];
            tag_q[i]  <= tag_q[i-1];
            dest_q[i] <= dest_q[i-1];
        end
    end

    // ============================================================
    // Completion
    // ============================================================

    assign done_o      = vld_q[LAT-1];
    assign done_tag_o  = tag_q[LAT-1];
    assign done_dest_o = dest_q[LAT-1];
    // MULHU picks the upper half, MUL the lower one
    assign result_o    = high_q[LAT-1] ? prod_q[LAT-1][2*`BACKEND_DATA_WIDTH-1:`BACKEND_DATA_WIDTH]
                                       : prod_q[LAT-1][`BACKEND_DATA_WIDTH-1:0];

endmodule : mul_unit

`default_nettype wire

// File: hdl/alu_unit.sv
`timescale 1ns/1ps
`default_nettype none

module alu_unit (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  logic                      start_i,
    input  backend_op_pkg::opcode_t   op_i,
    input  backend_op_pkg::word_t     a_i,
    input  backend_op_pkg::word_t     b_i,
    input  backend_op_pkg::reg_addr_t dest_i,
    input  backend_rob_pkg::tag_t     tag_i,
    output logic                      done_o,
    output backend_rob_pkg::tag_t     done_tag_o,
    output backend_op_pkg::reg_addr_t done_dest_o,
    output backend_op_pkg::word_t     result_o
);

    import backend_op_pkg::*;

    word_t result_d;

    // Result of the current operation, ready within the cycle
    always_comb begin
        case (op_i)
            OP_ADD:  result_d = a_i + b_i;
            OP_SUB:  result_d = a_i - b_i;
            OP_AND:  result_d = a_i & b_i;
            OP_OR:   result_d = a_i | b_i;
            OP_XOR:  result_d = a_i ^ b_i;
            // Shift amount is the low five bits of b
            OP_SLL:  result_d = a_i << b_i[4:0];
            // Multiplies never reach this unit
            default: result_d = '0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            done_o <= 1'b0;
        end else begin
            done_o <= start_i;
        end
    end

    // Tag and destination travel with the result
    always_ff @(posedge clk_i) begin
        if (start_i) begin
            result_o    <= result_d;
            done_tag_o  <= tag_i;
            done_dest_o <= dest_i;
        end
    end

endmodule : alu_unit

`default_nettype wire

// File: hdl/issue_stage.sv
`timescale 1ns/1ps
`default_nettype none

module issue_stage (
    input  logic                      clk_i,
    input  logic                      rst_n_i,

    // Instruction from the front end, one per cycle at most
    input  logic                      issue_valid_i,
    input  backend_op_pkg::opcode_t   issue_op_i,
    input  backend_op_pkg::word_t     issue_a_i,
    input  backend_op_pkg::word_t     issue_b_i,
    input  backend_op_pkg::reg_addr_t issue_dest_i,

    // Dispatch towards the execution units
    output logic                      alu_start_o,
    output backend_op_pkg::opcode_t   alu_op_o,
    output logic                      mul_start_o,
    output logic                      mul_high_o,
    output backend_op_pkg::word_t     op_a_o,
    output backend_op_pkg::word_t     op_b_o,
    output backend_op_pkg::reg_addr_t dest_o,
    output backend_rob_pkg::tag_t     tag_o,

    // Allocation notice for the reorder buffer
    output logic                      alloc_valid_o
);

    import backend_op_pkg::*;
    import backend_rob_pkg::*;

    // Next tag to hand out, i.e. the tail of the reorder buffer
    tag_t tail_tag;
    logic is_mul;

    // Both multiply flavours share the multiplier
    assign is_mul = (issue_op_i == OP_MUL) || (issue_op_i == OP_MULHU);

    // Strobes and the tag counter
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            alu_start_o   <= 1'b0;
            mul_start_o   <= 1'b0;
            alloc_valid_o <= 1'b0;
            tail_tag      <= '0;
            tag_o         <= '0;
        end else begin
            // Exactly one unit gets the instruction
            alu_start_o   <= issue_valid_i && !is_mul;
            mul_start_o   <= issue_valid_i && is_mul;
            alloc_valid_o <= issue_valid_i;
            if (issue_valid_i) begin
                tag_o    <= tail_tag;
                tail_tag <= tail_tag + 1'b1;
            end
        end
    end

    // Instruction payload, only meaningful alongside a start strobe
    always_ff @(posedge clk_i) begin
        if (issue_valid_i) begin
            alu_op_o   <= issue_op_i;
            mul_high_o <= (issue_op_i == OP_MULHU);
            op_a_o     <= issue_a_i;
            op_b_o     <= issue_b_i;
            dest_o     <= issue_dest_i;
        end
    end

endmodule : issue_stage

`default_nettype wire

// File: hdl/backend_rob_pkg.sv
`default_nettype none

`include "backend_consts.svh"

package backend_rob_pkg;

    // Reorder tag, handed out in issue order and wrapping modulo the depth
    typedef logic [`BACKEND_TAG_WIDTH-1:0] tag_t;

    // Life cycle of a reorder entry
    // FREE until allocated at issue, PENDING while a unit works on it,
    // DONE once the result sits in the buffer waiting for its turn
    typedef enum logic [1:0] {
        ENTRY_FREE    = 2'b00,
        ENTRY_PENDING = 2'b01,
        ENTRY_DONE    = 2'b10
    } entry_state_t;

endpackage : backend_rob_pkg

`default_nettype wire

// File: hdl/backend_op_pkg.sv
`default_nettype none

`include "backend_consts.svh"

package backend_op_pkg;

    // Operations understood by the back end
    // The two multiply codes go to the multiplier, everything else to the ALU
    typedef enum logic [2:0] {
        OP_ADD   = 3'd0,
        OP_SUB   = 3'd1,
        OP_AND   = 3'd2,
        OP_OR    = 3'd3,
        OP_XOR   = 3'd4,
        OP_SLL   = 3'd5,
        OP_MUL   = 3'd6,
        OP_MULHU = 3'd7
    } opcode_t;

    // One data word, used for operands and results alike
    typedef logic [`BACKEND_DATA_WIDTH-1:0] word_t;

    // Architectural destination register index
    typedef logic [`BACKEND_REG_ADDR_WIDTH-1:0] reg_addr_t;

endpackage : backend_op_pkg

`default_nettype wire

// File: include/backend_consts.svh
`ifndef BACKEND_CONSTS_SVH
`define BACKEND_CONSTS_SVH

// ============================================================
// Back end sizing
// ============================================================

// Width of operands and results
`define BACKEND_DATA_WIDTH 32

// Width of a destination register address
`define BACKEND_REG_ADDR_WIDTH 5

// Number of reorder entries, kept a power of two so tags wrap naturally
`define BACKEND_ROB_DEPTH 8

// Tag width, log2 of the reorder depth
`define BACKEND_TAG_WIDTH 3

// Multiplier pipeline depth in cycles
// Must stay at or below the reorder depth minus two, since occupancy peaks at latency plus two
`define BACKEND_MUL_LATENCY 3

`endif
